// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int block_words = 16;
    localparam int offset_w    = 4;
    localparam int tag_w       = 12;
    localparam int ddr_addr_w  = 28;

    typedef logic [15:0]                   word_t;
    typedef logic [block_words-1:0]        slice_t;   // one bit per word of the block
    typedef logic [tag_w+offset_w-1:0]     cpu_addr_t;
    typedef logic [tag_w-1:0]              tag_t;
    typedef logic [offset_w-1:0]           offset_t;
    typedef logic [ddr_addr_w-1:0]         ddr_addr_t;
    typedef logic [offset_w:0]             cnt_t;     // room to count past the last word

    // processor commands, same codes as the AP controller
    typedef enum logic [2:0] {
        cmd_none      = 3'd0,
        cmd_row_load  = 3'd1,
        cmd_row_store = 3'd2,
        cmd_col_load  = 3'd3,
        cmd_col_store = 3'd4
    } cache_cmd_t;

    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_writeback = 3'd1,
        st_fill_req  = 3'd2,
        st_fill      = 3'd3,
        st_access    = 3'd4,
        st_done      = 3'd5
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/dcache_tag.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag import dcache_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire tag_t   lookup_tag,
    input  wire         fill_done,
    input  wire         mark_dirty,
    output logic        hit,
    output logic        dirty,
    output tag_t        cur_tag
);

    logic valid;

    always_ff @(posedge clk) begin
        if (fill_done) begin
            cur_tag <= lookup_tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= 1'b0;
            dirty <= 1'b0;
        end else if (fill_done) begin
            valid <= 1'b1;
            dirty <= 1'b0;   // fresh copy of DDR
        end else if (mark_dirty) begin
            dirty <= 1'b1;
        end
    end

    assign hit = valid && (cur_tag == lookup_tag);

    // stores only ever land on the line that holds the requested block
    assert property (@(posedge clk) disable iff (!rst)
        mark_dirty |-> hit);

endmodule

`default_nettype wire

// File: verilog/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array import dcache_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             busy,
    input  wire             access_en,
    input  wire cache_cmd_t req_cmd,
    input  wire offset_t    req_offset,
    input  wire offset_t    req_col,
    input  wire word_t      row_wr_data,
    input  wire slice_t     col_wr_data,
    input  wire             fill_word_valid,
    input  wire offset_t    fill_offset,
    input  wire word_t      fill_word,
    input  wire offset_t    wb_offset,
    output word_t           row_rd_data,
    output slice_t          col_rd_data,
    output word_t           wb_word
);

    word_t  mem [block_words];
    word_t  row_wd_q;
    slice_t col_wd_q;

    // store operands sampled with the command, kept across a miss
    always_ff @(posedge clk) begin
        if (!busy) begin
            row_wd_q <= row_wr_data;
            col_wd_q <= col_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_word_valid) begin
            mem[fill_offset] <= fill_word;
        end else if (access_en) begin
            case (req_cmd)
                cmd_row_store: mem[req_offset] <= row_wd_q;
                cmd_col_store: begin
                    for (int i = 0; i < block_words; i++) begin
                        mem[i][req_col] <= col_wd_q[i];   // bit i of slice to word i
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            row_rd_data <= '0;
            col_rd_data <= '0;
        end else if (access_en) begin
            if (req_cmd == cmd_row_load) begin
                row_rd_data <= mem[req_offset];
            end
            if (req_cmd == cmd_col_load) begin
                for (int i = 0; i < block_words; i++) begin
                    col_rd_data[i] <= mem[i][req_col];
                end
            end
        end
    end

    assign wb_word = mem[wb_offset];   // write-back reads without a register stage

    // the fill completes before the access state is entered
    assert property (@(posedge clk) disable iff (!rst)
        !(access_en && fill_word_valid));

endmodule

`default_nettype wire

// File: verilog/dcache_ddr_port.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ddr_port import dcache_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire ctrl_state_t state,
    input  wire tag_t        req_tag,
    input  wire tag_t        cur_tag,
    input  wire word_t       wb_word,
    input  wire word_t       fifo_data,
    input  wire              fifo_empty,
    output logic             fifo_rd_en,
    output logic             fill_word_valid,
    output offset_t          fill_offset,
    output word_t            fill_word,
    output offset_t          wb_offset,
    output logic             xfer_last,
    output ddr_addr_t        read_addr,
    output logic             store_req,
    output logic             store_valid,
    output ddr_addr_t        store_addr,
    output word_t            store_data
);

    cnt_t cnt;
    logic step;

    assign store_req  = (state == st_writeback);
    assign fifo_rd_en = (state == st_fill) && !fifo_empty;

    // one word crosses the port in this cycle
    assign step      = store_req || fifo_rd_en;
    assign xfer_last = step && (cnt == cnt_t'(block_words - 1));

    // back at zero whenever a transfer state is entered
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (state != st_writeback && state != st_fill) begin
            cnt <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign wb_offset   = cnt[offset_w-1:0];
    assign fill_offset = cnt[offset_w-1:0];

    // fill side, words go straight from the show-ahead FIFO to the array
    assign fill_word_valid = fifo_rd_en;
    assign fill_word       = fifo_data;
    assign read_addr       = {{(ddr_addr_w - tag_w - offset_w){1'b0}}, req_tag,
                              {offset_w{1'b0}}};

    // write-back side, no back-pressure so every cycle carries a word
    assign store_valid = store_req;
    assign store_data  = wb_word;
    assign store_addr  = {{(ddr_addr_w - tag_w - offset_w){1'b0}}, cur_tag, wb_offset};

    // a transfer never runs past the last word of the block
    assert property (@(posedge clk) disable iff (!rst)
        (state == st_writeback || state == st_fill) |-> !cnt[offset_w]);

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             cmd_valid,
    input  wire cache_cmd_t cmd,
    input  wire cpu_addr_t  addr,
    input  wire offset_t    col,
    input  wire             hit,
    input  wire             dirty,
    input  wire             xfer_last,
    output ctrl_state_t     state,
    output logic            busy,
    output logic            done,
    output logic            read_req,
    output cache_cmd_t      req_cmd,
    output offset_t         req_offset,
    output offset_t         req_col,
    output tag_t            req_tag,
    output logic            access_en
);

    ctrl_state_t state_nx;
    tag_t        tag_q;
    logic        accept;

    assign busy      = (state != st_idle);
    assign done      = (state == st_done);
    assign read_req  = (state == st_fill_req);   // single cycle, fill_req never repeats
    assign access_en = (state == st_access);

    assign accept = cmd_valid && !busy && (cmd != cmd_none);

    // idle looks up the incoming address, later states the latched one
    assign req_tag = busy ? tag_q : addr[offset_w +: tag_w];

    always_comb begin
        state_nx = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    if (hit) begin
                        state_nx = st_access;
                    end else if (dirty) begin
                        state_nx = st_writeback;
                    end else begin
                        state_nx = st_fill_req;
                    end
                end
            end
            st_writeback: begin
                if (xfer_last) begin
                    state_nx = st_fill_req;
                end
            end
            st_fill_req: state_nx = st_fill;
            st_fill: begin
                if (xfer_last) begin
                    state_nx = st_access;
                end
            end
            st_access:   state_nx = st_done;
            st_done:     state_nx = st_idle;
            default:     state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= state_nx;
        end
    end

    // request fields, held for the whole command
    always_ff @(posedge clk) begin
        if (accept) begin
            req_cmd    <= cmd;
            req_offset <= addr[offset_w-1:0];
            req_col    <= col;
            tag_q      <= addr[offset_w +: tag_w];
        end
    end

    // the DDR port only ends a transfer while one is running
    assert property (@(posedge clk) disable iff (!rst)
        xfer_last |-> (state == st_writeback || state == st_fill));

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    // processor side
    input  wire             cmd_valid,
    input  wire cache_cmd_t cmd,
    input  wire cpu_addr_t  addr,
    input  wire offset_t    col,
    input  wire word_t      row_wr_data,
    input  wire slice_t     col_wr_data,
    output logic            busy,
    output logic            done,
    output word_t           row_rd_data,
    output slice_t          col_rd_data,
    // DDR side
    output logic            read_req,
    output ddr_addr_t       read_addr,
    input  wire word_t      fifo_data,
    input  wire             fifo_empty,
    output logic            fifo_rd_en,
    output logic            store_req,
    output logic            store_valid,
    output ddr_addr_t       store_addr,
    output word_t           store_data
);

    ctrl_state_t state;
    cache_cmd_t  req_cmd;
    offset_t     req_offset;
    offset_t     req_col;
    tag_t        req_tag;
    tag_t        cur_tag;
    logic        access_en;
    logic        hit;
    logic        dirty;
    logic        xfer_last;
    logic        fill_done;
    logic        mark_dirty;
    logic        fill_word_valid;
    offset_t     fill_offset;
    word_t       fill_word;
    offset_t     wb_offset;
    word_t       wb_word;

    assign fill_done  = (state == st_fill) && xfer_last;   // last word of the line is in
    assign mark_dirty = access_en &&
                        (req_cmd == cmd_row_store || req_cmd == cmd_col_store);

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .addr       (addr),
        .col        (col),
        .hit        (hit),
        .dirty      (dirty),
        .xfer_last  (xfer_last),
        .state      (state),
        .busy       (busy),
        .done       (done),
        .read_req   (read_req),
        .req_cmd    (req_cmd),
        .req_offset (req_offset),
        .req_col    (req_col),
        .req_tag    (req_tag),
        .access_en  (access_en)
    );

    dcache_tag u_tag (
        .clk        (clk),
        .rst        (rst),
        .lookup_tag (req_tag),
        .fill_done  (fill_done),
        .mark_dirty (mark_dirty),
        .hit        (hit),
        .dirty      (dirty),
        .cur_tag    (cur_tag)
    );

    dcache_array u_array (
        .clk             (clk),
        .rst             (rst),
        .busy            (busy),
        .access_en       (access_en),
        .req_cmd         (req_cmd),
        .req_offset      (req_offset),
        .req_col         (req_col),
        .row_wr_data     (row_wr_data),
        .col_wr_data     (col_wr_data),
        .fill_word_valid (fill_word_valid),
        .fill_offset     (fill_offset),
        .fill_word       (fill_word),
        .wb_offset       (wb_offset),
        .row_rd_data     (row_rd_data),
        .col_rd_data     (col_rd_data),
        .wb_word         (wb_word)
    );

    dcache_ddr_port u_ddr_port (
        .clk             (clk),
        .rst             (rst),
        .state           (state),
        .req_tag         (req_tag),
        .cur_tag         (cur_tag),
        .wb_word         (wb_word),
        .fifo_data       (fifo_data),
        .fifo_empty      (fifo_empty),
        .fifo_rd_en      (fifo_rd_en),
        .fill_word_valid (fill_word_valid),
        .fill_offset     (fill_offset),
        .fill_word       (fill_word),
        .wb_offset       (wb_offset),
        .xfer_last       (xfer_last),
        .read_addr       (read_addr),
        .store_req       (store_req),
        .store_valid     (store_valid),
        .store_addr      (store_addr),
        .store_data      (store_data)
    );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

// File: sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int num_cmds   = 400;
    localparam int cmd_cycles = 80;
    localparam int clk_period = 4;

    logic       clk;
    logic       rst;
    logic       cmd_valid;
    cache_cmd_t cmd;
    cpu_addr_t  addr;
    offset_t    col;
    word_t      row_wr_data;
    slice_t     col_wr_data;
    word_t      fifo_data;
    logic       fifo_empty;
    logic       busy;
    logic       done;
    logic       read_req;
    logic       store_req;
    logic       store_valid;
    logic       fifo_rd_en;
    word_t      row_rd_data;
    slice_t     col_rd_data;
    ddr_addr_t  read_addr;
    ddr_addr_t  store_addr;
    word_t      store_data;

    integer     seed = 32'hde37_0014;
    word_t      ddr_mem [ddr_addr_t];   // only words that were written back
    word_t      fifo_q [$];
    tag_t       want_tag;               // block of the command in flight
    int         wb_total;
    int         sreq_total;
    int         req_total;
    int         pop_total;

    // reference cache
    logic       m_valid;
    logic       m_dirty;
    tag_t       m_tag;
    word_t      m_data [block_words];

    tag_t       tag_pool [3] = '{12'h0a5, 12'h3c1, 12'hf0e};

    tb_clk_gen u_clk (.clk(clk));

    dcache_top dut (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .addr        (addr),
        .col         (col),
        .row_wr_data (row_wr_data),
        .col_wr_data (col_wr_data),
        .busy        (busy),
        .done        (done),
        .row_rd_data (row_rd_data),
        .col_rd_data (col_rd_data),
        .read_req    (read_req),
        .read_addr   (read_addr),
        .fifo_data   (fifo_data),
        .fifo_empty  (fifo_empty),
        .fifo_rd_en  (fifo_rd_en),
        .store_req   (store_req),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic ddr_addr_t block_addr(tag_t t, offset_t o);
        return ddr_addr_t'({t, o});
    endfunction

    // initial DDR contents, mixes every address bit
    function automatic word_t mem_hash(ddr_addr_t a);
        logic [27:0] mix;
        mix = (a ^ (a >> 9)) * 28'h0b5c3a1;
        return mix[23:8] ^ 16'h6b3d;
    endfunction

    function automatic word_t ddr_read(ddr_addr_t a);
        if (ddr_mem.exists(a)) begin
            return ddr_mem[a];
        end
        return mem_hash(a);
    endfunction

    // DDR side, sampled with the DUT's own clock edge
    always @(posedge clk) begin
        if (store_valid) begin
            assert (store_req) else report_error("store_valid pulsed outside of a write-back");
            assert (store_addr == block_addr(m_tag, offset_t'(wb_total))) else
                report_error($sformatf("Error: store_addr got %h expected %h", store_addr,
                                       block_addr(m_tag, offset_t'(wb_total))));
            assert (store_data == m_data[offset_t'(wb_total)]) else
                report_error($sformatf("Error: store_data got %h expected %h", store_data,
                                       m_data[offset_t'(wb_total)]));
            ddr_mem[store_addr] = store_data;
            wb_total++;
        end
        if (store_req) begin
            sreq_total++;
        end
        if (read_req) begin
            assert (read_addr == block_addr(want_tag, '0)) else
                report_error($sformatf("Error: read_addr got %h expected %h", read_addr,
                                       block_addr(want_tag, '0)));
            for (int i = 0; i < block_words; i++) begin
                fifo_q.push_back(ddr_read(block_addr(want_tag, offset_t'(i))));
            end
            req_total++;
        end
        if (fifo_rd_en) begin
            assert (!fifo_empty) else report_error("fifo_rd_en was high while the FIFO was empty");
            void'(fifo_q.pop_front());
            pop_total++;
        end
        // show-ahead output with random empty gaps
        if (fifo_q.size() > 0 && ($unsigned($random(seed)) % 4) != 0) begin
            fifo_empty <= 1'b0;
            fifo_data  <= fifo_q[0];
        end else begin
            fifo_empty <= 1'b1;
            fifo_data  <= word_t'($random(seed));
        end
    end

    task automatic run_command();
        cache_cmd_t c;
        tag_t       t;
        offset_t    off;
        offset_t    cl;
        word_t      rw;
        slice_t     cw;
        slice_t     exp_slice;
        logic       was_hit;
        int         wb0;
        int         sreq0;
        int         req0;
        int         pop0;
        int         cycles;
        @(negedge clk);
        assert (!done && !busy) else report_error("done or busy still high after the command ended");
        c   = cache_cmd_t'(3'd1 + 3'($unsigned($random(seed)) % 4));
        t   = tag_pool[$unsigned($random(seed)) % 3];   // few tags so hits and misses mix
        off = offset_t'($random(seed));
        cl  = offset_t'($random(seed));
        rw  = word_t'($random(seed));
        cw  = slice_t'($random(seed));
        was_hit  = m_valid && (m_tag == t);
        want_tag = t;
        wb0   = wb_total;
        sreq0 = sreq_total;
        req0  = req_total;
        pop0  = pop_total;
        @(posedge clk);
        cmd_valid   <= 1'b1;
        cmd         <= c;
        addr        <= {t, off};
        col         <= cl;
        row_wr_data <= rw;
        col_wr_data <= cw;
        @(posedge clk);   // command sampled here
        cmd_valid <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!done) begin
                assert (busy) else report_error("busy was low while the command was running");
            end
        end while (!done);
        if (was_hit) begin
            assert (cycles == 2) else
                report_error($sformatf("Error: done latency got %h expected %h", cycles, 2));
            assert (wb_total == wb0 && sreq_total == sreq0 && req_total == req0 &&
                    pop_total == pop0) else
                report_error("DDR traffic was seen on a hit");
        end else begin
            assert (wb_total - wb0 == (m_dirty ? 16 : 0)) else
                report_error($sformatf("Error: store_valid count got %h expected %h",
                                       wb_total - wb0, m_dirty ? 16 : 0));
            assert (sreq_total - sreq0 == (m_dirty ? 16 : 0)) else
                report_error($sformatf("Error: store_req cycles got %h expected %h",
                                       sreq_total - sreq0, m_dirty ? 16 : 0));
            assert (req_total - req0 == 1) else
                report_error($sformatf("Error: read_req count got %h expected %h",
                                       req_total - req0, 1));
            assert (pop_total - pop0 == 16 && fifo_q.size() == 0) else
                report_error($sformatf("Error: fifo_rd_en count got %h expected %h",
                                       pop_total - pop0, 16));
            for (int i = 0; i < block_words; i++) begin
                m_data[i] = ddr_read(block_addr(t, offset_t'(i)));
            end
            m_tag   = t;
            m_valid = 1'b1;
            m_dirty = 1'b0;
        end
        case (c)
            cmd_row_load: begin
                assert (row_rd_data == m_data[off]) else
                    report_error($sformatf("Error: row_rd_data got %h expected %h",
                                           row_rd_data, m_data[off]));
            end
            cmd_col_load: begin
                for (int i = 0; i < block_words; i++) begin
                    exp_slice[i] = m_data[i][cl];
                end
                assert (col_rd_data == exp_slice) else
                    report_error($sformatf("Error: col_rd_data got %h expected %h",
                                           col_rd_data, exp_slice));
            end
            cmd_row_store: begin
                m_data[off] = rw;
                m_dirty     = 1'b1;
            end
            cmd_col_store: begin
                for (int i = 0; i < block_words; i++) begin
                    m_data[i][cl] = cw[i];   // only bit cl of each word moves
                end
                m_dirty = 1'b1;
            end
            default: ;
        endcase
    endtask

    initial begin
        cmd_valid   = 1'b0;
        cmd         = cmd_none;
        addr        = '0;
        col         = '0;
        row_wr_data = '0;
        col_wr_data = '0;
        fifo_data   = '0;
        fifo_empty  = 1'b1;
        rst         = 1'b0;
        want_tag    = '0;
        m_valid     = 1'b0;
        m_dirty     = 1'b0;
        m_tag       = '0;
        foreach (m_data[i]) begin
            m_data[i] = '0;
        end
        repeat (7) @(posedge clk);
        @(negedge clk);
        assert (!busy && !done && !read_req && !store_req && !store_valid && !fifo_rd_en) else
            report_error("control outputs were not low during reset");
        @(posedge clk);
        rst <= 1'b1;
        for (int n = 0; n < num_cmds; n++) begin
            run_command();
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #(num_cmds * cmd_cycles * clk_period + 20 * clk_period);
        report_error("watchdog timeout, the commands did not finish in time");
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/dcache_pkg.sv
verilog/dcache_tag.sv
verilog/dcache_array.sv
verilog/dcache_ddr_port.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/tb_clk_gen.sv
sim/tb_dcache.sv

// File: Makefile
TOP := tb_dcache

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
